// ==== rtl/rp_params.svh ====
// analog signal path parameters
// converter and sample widths, gain format and post-multiply scaling

`ifndef RP_PARAMS_SVH
`define RP_PARAMS_SVH

`define RP_ADC_BITS     14  // ADC and DAC resolution
`define RP_SAMPLE_BITS  14  // signed internal sample
`define RP_KP_BITS      12  // signed proportional gain
`define RP_KP_SHIFT     8   // gain of 256 is unity

`endif

// ==== rtl/analog_io_pkg.sv ====
// converter pin types
// raw ADC codes and DAC codes, both unsigned with negative slope

`include "rp_params.svh"

package analog_io_pkg;

  // ----------------------------------------
  // pin side words

  // raw ADC code, 0 is full positive scale
  typedef logic [`RP_ADC_BITS-1:0] adc_raw_t;

  // DAC code, 8191 is mid scale
  typedef logic [`RP_ADC_BITS-1:0] dac_code_t;

endpackage

// ==== rtl/dsp_pkg.sv ====
// internal arithmetic types
// two's complement samples, gains, errors and full-width products

`include "rp_params.svh"

package dsp_pkg;

  // ----------------------------------------
  // sample domain

  typedef logic signed [`RP_SAMPLE_BITS-1:0] sample_t;  // -8192..8191

  // one extra bit so setpoint minus sample never wraps
  typedef logic signed [`RP_SAMPLE_BITS:0] err_t;

  // ----------------------------------------
  // gain domain

  typedef logic signed [`RP_KP_BITS-1:0] kp_t;  // 256 is unity

  // full product of err_t and kp_t, no overflow possible
  typedef logic signed [`RP_SAMPLE_BITS+`RP_KP_BITS:0] prod_t;

endpackage

// ==== rtl/sample_if.sv ====
// stage to stage sample link
// one pair of samples per clock plus a clip flag per channel

interface sample_if import dsp_pkg::*; ();

  sample_t dat_a;   // channel a sample
  sample_t dat_b;   // channel b sample
  logic    clip_a;  // a saturated somewhere upstream
  logic    clip_b;  // b saturated somewhere upstream

  modport src (
    output dat_a, dat_b, clip_a, clip_b
  );

  modport dst (
    input  dat_a, dat_b, clip_a, clip_b
  );

endinterface

// ==== rtl/adc_frontend.sv ====
// ADC front end
// registers both raw ADC codes and turns them into signed samples

`include "rp_params.svh"

module adc_frontend import dsp_pkg::*, analog_io_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  adc_raw_t adc_dat_a_i,  // CH1 raw code
  input  adc_raw_t adc_dat_b_i,  // CH2 raw code
  sample_if.src    out_o
);

  // ----------------------------------------
  // code conversion

  // 8191 - raw, keep msb and flip the rest
  function automatic sample_t raw_to_sample(input adc_raw_t raw);
    return {raw[`RP_ADC_BITS-1], ~raw[`RP_ADC_BITS-2:0]};
  endfunction

  sample_t dat_a_q;  // registered CH1 sample
  sample_t dat_b_q;  // registered CH2 sample

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_a_q <= '0;
      dat_b_q <= '0;
    end else begin
      dat_a_q <= raw_to_sample(adc_dat_a_i);  // 0 -> +8191
      dat_b_q <= raw_to_sample(adc_dat_b_i);  // 16383 -> -8192
    end
  end

  // ----------------------------------------
  // to the feedback stage

  assign out_o.dat_a  = dat_a_q;
  assign out_o.dat_b  = dat_b_q;
  assign out_o.clip_a = 1'b0;  // input never clips here
  assign out_o.clip_b = 1'b0;

endmodule

// ==== rtl/pid_gain.sv ====
// proportional feedback stage
// per channel: kp * (setpoint - sample), scaled down by 2^RP_KP_SHIFT
// and clamped to the sample range, with a clip flag per channel

`include "rp_params.svh"

module pid_gain import dsp_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n_i,
  sample_if.dst   in_i,
  input  sample_t set_a_i,  // CH1 setpoint
  input  sample_t set_b_i,  // CH2 setpoint
  input  kp_t     kp_a_i,   // CH1 gain
  input  kp_t     kp_b_i,   // CH2 gain
  sample_if.src   out_o
);

  localparam int PW = $bits(prod_t);   // product width
  localparam int SB = `RP_SAMPLE_BITS;  // sample width

  // clamp a scaled product into -8192..8191
  function automatic sample_t clamp_prod(input prod_t p, output logic clip);
    sample_t r;
    if (&p[PW-1:SB-1] || ~|p[PW-1:SB-1]) begin  // upper bits all sign
      clip = 1'b0;
      r    = p[SB-1:0];
    end else begin
      clip = 1'b1;
      r    = {p[PW-1], {(SB-1){~p[PW-1]}}};  // max or min
    end
    return r;
  endfunction

  // ----------------------------------------
  // error, product, scaling

  err_t    err_a, err_b;    // setpoint minus sample
  prod_t   prod_a, prod_b;  // full width product
  prod_t   scl_a, scl_b;    // after arithmetic shift
  sample_t nxt_a, nxt_b;    // clamped result
  logic    sat_a, sat_b;    // clamp was active

  always_comb begin
    err_a  = err_t'(set_a_i) - err_t'(in_i.dat_a);
    err_b  = err_t'(set_b_i) - err_t'(in_i.dat_b);
    prod_a = prod_t'(err_a) * prod_t'(kp_a_i);
    prod_b = prod_t'(err_b) * prod_t'(kp_b_i);
    scl_a  = prod_a >>> `RP_KP_SHIFT;  // floor division
    scl_b  = prod_b >>> `RP_KP_SHIFT;
    nxt_a  = clamp_prod(scl_a, sat_a);
    nxt_b  = clamp_prod(scl_b, sat_b);
  end

  // ----------------------------------------
  // output register

  sample_t dat_a_q, dat_b_q;
  logic    clip_a_q, clip_b_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_a_q  <= '0;
      dat_b_q  <= '0;
      clip_a_q <= 1'b0;
      clip_b_q <= 1'b0;
    end else begin
      dat_a_q  <= nxt_a;
      dat_b_q  <= nxt_b;
      clip_a_q <= sat_a | in_i.clip_a;  // keep upstream clips too
      clip_b_q <= sat_b | in_i.clip_b;
    end
  end

  assign out_o.dat_a  = dat_a_q;
  assign out_o.dat_b  = dat_b_q;
  assign out_o.clip_a = clip_a_q;
  assign out_o.clip_b = clip_b_q;

endmodule

// ==== rtl/dac_mix.sv ====
// offset mixer
// adds a static offset per channel to the feedback output, saturates
// to the sample range and merges the clip flags

`include "rp_params.svh"

module dac_mix import dsp_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n_i,
  sample_if.dst   in_i,
  input  sample_t ofs_a_i,  // CH1 offset
  input  sample_t ofs_b_i,  // CH2 offset
  sample_if.src   out_o
);

  localparam int SB = `RP_SAMPLE_BITS;

  // top two bits differ -> overflow, pick max or min
  function automatic sample_t sat_sum(input err_t s, output logic clip);
    sample_t r;
    clip = s[SB] ^ s[SB-1];
    if (clip)
      r = {s[SB], {(SB-1){~s[SB]}}};
    else
      r = s[SB-1:0];
    return r;
  endfunction

  // ----------------------------------------
  // sum and saturation

  err_t    sum_a, sum_b;  // one bit of headroom
  sample_t nxt_a, nxt_b;
  logic    sat_a, sat_b;

  always_comb begin
    sum_a = err_t'(in_i.dat_a) + err_t'(ofs_a_i);
    sum_b = err_t'(in_i.dat_b) + err_t'(ofs_b_i);
    nxt_a = sat_sum(sum_a, sat_a);
    nxt_b = sat_sum(sum_b, sat_b);
  end

  sample_t dat_a_q, dat_b_q;
  logic    clip_a_q, clip_b_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dat_a_q  <= '0;
      dat_b_q  <= '0;
      clip_a_q <= 1'b0;
      clip_b_q <= 1'b0;
    end else begin
      dat_a_q  <= nxt_a;
      dat_b_q  <= nxt_b;
      clip_a_q <= in_i.clip_a | sat_a;  // feedback or mix clip
      clip_b_q <= in_i.clip_b | sat_b;
    end
  end

  assign out_o.dat_a  = dat_a_q;
  assign out_o.dat_b  = dat_b_q;
  assign out_o.clip_a = clip_a_q;
  assign out_o.clip_b = clip_b_q;

endmodule

// ==== rtl/dac_output.sv ====
// DAC output stage
// converts signed samples back to negative-slope DAC codes and keeps
// sticky clip indicators for the LEDs

`include "rp_params.svh"

module dac_output import dsp_pkg::*, analog_io_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  sample_if.dst     in_i,
  input  logic      clr_clip_i,   // clear sticky flags
  output dac_code_t dac_dat_a_o,  // CH1 DAC code
  output dac_code_t dac_dat_b_o,  // CH2 DAC code
  output logic [1:0] clip_led_o   // [0] CH1, [1] CH2
);

  localparam dac_code_t CODE_ZERO = dac_code_t'((1 << (`RP_ADC_BITS-1)) - 1);  // 8191

  // 8191 - sample, same bit trick as the front end
  function automatic dac_code_t sample_to_code(input sample_t s);
    return {s[`RP_SAMPLE_BITS-1], ~s[`RP_SAMPLE_BITS-2:0]};
  endfunction

  // ----------------------------------------
  // code registers

  dac_code_t code_a_q, code_b_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      code_a_q <= CODE_ZERO;  // sample zero at mid scale
      code_b_q <= CODE_ZERO;
    end else begin
      code_a_q <= sample_to_code(in_i.dat_a);
      code_b_q <= sample_to_code(in_i.dat_b);
    end
  end

  // ----------------------------------------
  // sticky clip flags

  logic [1:0] clip_q;

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i)
      clip_q <= 2'b00;
    else if (clr_clip_i)
      clip_q <= 2'b00;  // clear beats a new clip
    else
      clip_q <= clip_q | {in_i.clip_b, in_i.clip_a};
  end

  assign dac_dat_a_o = code_a_q;
  assign dac_dat_b_o = code_b_q;
  assign clip_led_o  = clip_q;

endmodule

// ==== rtl/analog_top.sv ====
// analog signal path top
// ADC front end -> proportional feedback -> offset mix -> DAC output
// four registered stages in the adc_clk domain

module analog_top import dsp_pkg::*, analog_io_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_n_i,      // async, active low
  // ADC
  input  adc_raw_t   adc_dat_a_i,  // CH1
  input  adc_raw_t   adc_dat_b_i,  // CH2
  // feedback control levels
  input  sample_t    set_a_i,
  input  sample_t    set_b_i,
  input  kp_t        kp_a_i,
  input  kp_t        kp_b_i,
  // static offsets, stand in for the generator
  input  sample_t    ofs_a_i,
  input  sample_t    ofs_b_i,
  input  logic       clr_clip_i,
  // DAC
  output dac_code_t  dac_dat_a_o,  // CH1
  output dac_code_t  dac_dat_b_o,  // CH2
  output logic [1:0] clip_led_o
);

  // ----------------------------------------
  // stage links

  sample_if s_adc ();  // front end -> feedback
  sample_if s_pid ();  // feedback -> mix
  sample_if s_mix ();  // mix -> output

  // ----------------------------------------
  // stages

  adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .out_o       (s_adc.src)
  );

  pid_gain i_pid (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .in_i    (s_adc.dst),
    .set_a_i (set_a_i),
    .set_b_i (set_b_i),
    .kp_a_i  (kp_a_i),
    .kp_b_i  (kp_b_i),
    .out_o   (s_pid.src)
  );

  dac_mix i_mix (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .in_i    (s_pid.dst),
    .ofs_a_i (ofs_a_i),
    .ofs_b_i (ofs_b_i),
    .out_o   (s_mix.src)
  );

  dac_output i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .in_i        (s_mix.dst),
    .clr_clip_i  (clr_clip_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .clip_led_o  (clip_led_o)
  );

endmodule

// ==== dv/analog_tb.sv ====
// analog path testbench
// drives the four stage path with directed and random levels and checks
// every DAC output against a cycle aligned reference model

`include "rp_params.svh"

module analog_tb import dsp_pkg::*, analog_io_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HIST        = 1024;  // history depth in edges
  localparam int N_ZERO      = 20;    // gain zero cycles
  localparam int N_LOOP      = 50;    // loopback cycles
  localparam int N_RAND      = 400;   // random cycles
  localparam int N_DIRECTED  = 60;    // bound on the directed part
  localparam int TEST_CYCLES = 6 + N_ZERO + N_LOOP + N_RAND + N_DIRECTED;
  localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 500;

  logic       adc_clk;
  logic       rst_n_i;
  adc_raw_t   adc_dat_a_i, adc_dat_b_i;
  sample_t    set_a_i, set_b_i;
  kp_t        kp_a_i, kp_b_i;
  sample_t    ofs_a_i, ofs_b_i;
  logic       clr_clip_i;
  dac_code_t  dac_dat_a_o, dac_dat_b_o;
  logic [1:0] clip_led_o;

  int         seed        = 17903;
  int         edge_cnt    = 0;      // rising edges seen so far
  logic [1:0] led_exp     = 2'b00;  // modelled sticky flags

  // levels as sampled at each rising edge, indexed [edge][channel]
  int adc_h [HIST][2];
  int set_h [HIST][2];
  int kp_h  [HIST][2];
  int ofs_h [HIST][2];
  bit clr_h [HIST];

  analog_top i_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  // ----------------------------------------
  // reference model

  function automatic int floor_div(int p, int d);
    if (p >= 0)
      return p / d;
    return -((-p + d - 1) / d);  // round toward minus infinity
  endfunction

  function automatic void limit_to_sample(input int v, output int y, output bit clip);
    clip = (v > 8191) || (v < -8192);
    y    = (v > 8191) ? 8191 : (v < -8192) ? -8192 : v;
  endfunction

  function automatic void ref_dac(input int raw, input int setp, input int kp,
                                  input int ofs, output int code, output bit clip);
    int smp;
    int fb;
    int mixed;
    bit clip_fb;
    bit clip_mix;
    smp = 8191 - raw;  // negative slope ADC
    limit_to_sample(floor_div((setp - smp) * kp, 1 << `RP_KP_SHIFT), fb, clip_fb);
    limit_to_sample(fb + ofs, mixed, clip_mix);
    code = 8191 - mixed;  // negative slope DAC
    clip = clip_fb | clip_mix;
  endfunction

  // gain -256 with setpoint 0 and no offset gives the raw code back
  function automatic bit is_loopback(int n, int ch);
    return kp_h[n-2][ch] == -256 && set_h[n-2][ch] == 0 && ofs_h[n-1][ch] == 0 &&
           adc_h[n-3][ch] > 0 && adc_h[n-3][ch] < 16383;
  endfunction

  task automatic report_mismatch(string what);
    $display("Mismatch at %0t: %s", $time, what);
    $display("Verification failed");
  endtask

  // ----------------------------------------
  // input history and output comparison

  always @(posedge adc_clk) begin : record_inputs
    edge_cnt = edge_cnt + 1;
    if (edge_cnt < HIST) begin
      adc_h[edge_cnt][0] = int'(adc_dat_a_i);
      adc_h[edge_cnt][1] = int'(adc_dat_b_i);
      set_h[edge_cnt][0] = int'(set_a_i);  // sign extended
      set_h[edge_cnt][1] = int'(set_b_i);
      kp_h[edge_cnt][0]  = int'(kp_a_i);
      kp_h[edge_cnt][1]  = int'(kp_b_i);
      ofs_h[edge_cnt][0] = int'(ofs_a_i);
      ofs_h[edge_cnt][1] = int'(ofs_b_i);
      clr_h[edge_cnt]    = clr_clip_i;
    end
  end

  // adc from edge n-3, setpoint and gain from n-2, offset from n-1
  always @(negedge adc_clk) begin : compare_outputs
    int n;
    int ch;
    int got [2];
    int want [2];
    bit clip [2];
    n      = edge_cnt;
    got[0] = int'(dac_dat_a_o);
    got[1] = int'(dac_dat_b_o);
    if (n >= 1 && n < HIST) begin
      for (ch = 0; ch < 2; ch++) begin
        want[ch] = 8191;  // mid scale during reset
        clip[ch] = 1'b0;
        if (n >= 3)
          ref_dac(adc_h[n-3][ch], set_h[n-2][ch], kp_h[n-2][ch], ofs_h[n-1][ch],
                  want[ch], clip[ch]);
        assert (got[ch] == want[ch]) else begin
          report_mismatch($sformatf("channel %0d code %0d, expected %0d", ch, got[ch],
                                    want[ch]));
          $fatal(1);
        end
        if (n >= 3 && is_loopback(n, ch)) begin
          assert (got[ch] == adc_h[n-3][ch]) else begin
            report_mismatch($sformatf("channel %0d loopback code %0d, expected %0d", ch,
                                      got[ch], adc_h[n-3][ch]));
            $fatal(1);
          end
        end
      end
      if (n < 3 || clr_h[n])
        led_exp = 2'b00;  // clear beats a new clip
      else
        led_exp = led_exp | {clip[1], clip[0]};
      assert (clip_led_o == led_exp) else begin
        report_mismatch($sformatf("clip_led_o %b, expected %b", clip_led_o, led_exp));
        $fatal(1);
      end
    end
  end

  // ----------------------------------------
  // stimulus helpers

  task automatic next_drive_point();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic set_channel(int ch, int raw, int setp, int kp, int ofs);
    if (ch == 0) begin
      adc_dat_a_i = adc_raw_t'(raw);
      set_a_i     = sample_t'(setp);
      kp_a_i      = kp_t'(kp);
      ofs_a_i     = sample_t'(ofs);
    end else begin
      adc_dat_b_i = adc_raw_t'(raw);
      set_b_i     = sample_t'(setp);
      kp_b_i      = kp_t'(kp);
      ofs_b_i     = sample_t'(ofs);
    end
  endtask

  function automatic int rand_raw();
    return ($unsigned($random(seed)) % 16382) + 1;  // 1..16382
  endfunction

  task automatic expect_outputs(int want_a, int want_b, logic [1:0] want_led, string what);
    @(negedge adc_clk);
    assert (int'(dac_dat_a_o) == want_a && int'(dac_dat_b_o) == want_b &&
            clip_led_o == want_led) else begin
      report_mismatch($sformatf("%s: codes %0d %0d leds %b, expected %0d %0d leds %b",
                                what, dac_dat_a_o, dac_dat_b_o, clip_led_o,
                                want_a, want_b, want_led));
      $fatal(1);
    end
  endtask

  // ----------------------------------------
  // test sequence

  initial begin : run_tests
    int i;
    int ch;
    rst_n_i    = 1'b0;
    clr_clip_i = 1'b0;
    for (ch = 0; ch < 2; ch++) begin
      set_channel(ch, 8191, 0, 0, 0);  // idle at sample zero
      adc_h[0][ch] = 8191;
    end
    repeat (2) @(posedge adc_clk);
    #1 rst_n_i = 1'b1;
    repeat (4) next_drive_point();

    for (i = 0; i < N_ZERO; i++) begin  // gain zero keeps the output at mid scale
      next_drive_point();
      set_channel(0, rand_raw(), 0, 0, 0);
      set_channel(1, rand_raw(), 0, 0, 0);
    end
    expect_outputs(8191, 8191, 2'b00, "gain zero");

    for (i = 0; i < N_LOOP; i++) begin  // unity inverting gain
      next_drive_point();
      set_channel(0, rand_raw(), 0, -256, 0);
      set_channel(1, rand_raw(), 0, -256, 0);
    end

    for (i = 0; i < N_RAND; i++) begin
      next_drive_point();
      if (i % 8 == 0) begin  // levels held for 8 cycles
        for (ch = 0; ch < 2; ch++)
          set_channel(ch, rand_raw(), $random(seed), $random(seed) % 512,
                      $random(seed) % 2048);
      end else begin
        adc_dat_a_i = adc_raw_t'($random(seed));
        adc_dat_b_i = adc_raw_t'($random(seed));
      end
      clr_clip_i = ($random(seed) % 16 == 0);  // occasional clear
    end

    // idle, then clear whatever the random run left
    next_drive_point();
    clr_clip_i = 1'b0;
    set_channel(0, 8191, 0, 0, 0);
    set_channel(1, 8191, 0, 0, 0);
    repeat (4) next_drive_point();
    clr_clip_i = 1'b1;
    next_drive_point();
    clr_clip_i = 1'b0;
    expect_outputs(8191, 8191, 2'b00, "idle after clear");

    next_drive_point();
    set_channel(0, 16383, 8191, 2047, 0);  // huge error clamps high
    set_channel(1, 16383, 0, -256, -100);  // -8192 - 100 clamps in the mix
    repeat (4) next_drive_point();
    expect_outputs(0, 16383, 2'b11, "saturation");
    next_drive_point();
    set_channel(0, 8191, 0, 0, 0);
    set_channel(1, 8191, 0, 0, 0);
    repeat (5) next_drive_point();
    expect_outputs(8191, 8191, 2'b11, "sticky after release");

    next_drive_point();
    clr_clip_i = 1'b1;  // no clip arriving
    next_drive_point();
    clr_clip_i = 1'b0;
    expect_outputs(8191, 8191, 2'b00, "clear pulse");

    next_drive_point();
    set_channel(0, 16383, 8191, 2047, 0);
    repeat (4) next_drive_point();
    expect_outputs(0, 8191, 2'b01, "clip on channel 0");
    next_drive_point();
    clr_clip_i = 1'b1;  // clip still arriving
    next_drive_point();
    clr_clip_i = 1'b0;
    expect_outputs(0, 8191, 2'b00, "clear during clip");
    expect_outputs(0, 8191, 2'b01, "clip after clear");

    next_drive_point();
    set_channel(0, 8191, 0, 0, 0);
    repeat (5) next_drive_point();

    $display("Verification passed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1);
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/analog_io_pkg.sv
rtl/dsp_pkg.sv
rtl/sample_if.sv
rtl/adc_frontend.sv
rtl/pid_gain.sv
rtl/dac_mix.sv
rtl/dac_output.sv
rtl/analog_top.sv
dv/analog_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the analog path testbench with Verilator and run it
verilator --binary --assert --timescale 1ns/100ps -f vlog.f --top-module analog_tb \
  -o analog_sim && ./obj_dir/analog_sim || exit 1
